/* design/dma_consts.svh */
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Bus and user word widths
`define DMA_ADDR_W        32
`define DMA_DATA_W        64

// One burst is eight 64-bit beats
`define DMA_BURST_BEATS   8
`define DMA_BURST_BYTES   64

`define DMA_FIFO_DEPTH    64
`define DMA_INIT_CREDITS  4

// Ids on the system bus, requests out and responses in
`define DMA_FSAB_DID      4'h2
`define DMA_FSAB_SUBDID   4'h1

// Configuration bus device id and register offsets (low 4 address bits)
`define DMA_CFG_DID       4'h3
`define DMA_REG_START     4'h0
`define DMA_REG_LEN       4'h4
`define DMA_REG_CMD       4'h8

`endif

/* design/dma_pkg.sv */
`default_nettype none

`include "dma_consts.svh"

package dma_pkg;

	// Command register values
	typedef enum logic [1:0] {
		CMD_STOP         = 2'd0,
		CMD_TRIGGER_ONCE = 2'd1,
		CMD_AUTOTRIGGER  = 2'd2
	} dma_cmd_e;

	// Byte address on the system bus, also used for the length register
	typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;

	// One bus beat, one user word
	typedef logic [`DMA_DATA_W-1:0] dma_word_t;

	// Request mode field of the system bus
	typedef enum logic [1:0] {
		FSAB_IDLE  = 2'd0,
		FSAB_READ  = 2'd1,
		FSAB_WRITE = 2'd2
	} fsab_mode_e;

endpackage

`default_nettype wire

/* design/dma_cmd_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface dma_cmd_if import dma_pkg::*; ();

	dma_addr_t start_addr;
	dma_addr_t len;
	dma_cmd_e  cmd;
	// One-cycle pulse per command register write
	logic      cmd_written;
	// Engine asks decode to drop a finished trigger-once back to stop
	logic      cmd_clear;

	modport cfg (
		output start_addr,
		output len,
		output cmd,
		output cmd_written,
		input  cmd_clear
	);

	modport eng (
		input  start_addr,
		input  len,
		input  cmd,
		input  cmd_written,
		output cmd_clear
	);

endinterface

`default_nettype wire

/* design/csr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module csr_decode import dma_pkg::*; (
	input  logic        frame_clk,
	input  logic        frame_rst_b,
	input  logic        cfg_valid,
	input  logic [3:0]  cfg_did,
	input  dma_addr_t   cfg_addr,
	input  logic [31:0] cfg_data,
	output logic        cfg_ack,
	dma_cmd_if.cfg      cmd
);

	logic     dev_hit;
	logic     sel_start;
	logic     sel_len;
	logic     sel_cmd;
	dma_cmd_e cmd_in;

	assign dev_hit   = cfg_valid && (cfg_did == `DMA_CFG_DID);
	assign sel_start = dev_hit && (cfg_addr[3:0] == `DMA_REG_START);
	assign sel_len   = dev_hit && (cfg_addr[3:0] == `DMA_REG_LEN);
	assign sel_cmd   = dev_hit && (cfg_addr[3:0] == `DMA_REG_CMD);

	// Unknown command codes fall back to stop
	always_comb begin
		case (dma_cmd_e'(cfg_data[1:0]))
			CMD_TRIGGER_ONCE: cmd_in = CMD_TRIGGER_ONCE;
			CMD_AUTOTRIGGER:  cmd_in = CMD_AUTOTRIGGER;
			default:          cmd_in = CMD_STOP;
		endcase
	end

	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			cmd.start_addr  <= '0;
			cmd.len         <= '0;
			cmd.cmd         <= CMD_STOP;
			cmd.cmd_written <= 1'b0;
			cfg_ack         <= 1'b0;
		end else begin
			// Only decoded offsets are acknowledged
			cfg_ack         <= sel_start || sel_len || sel_cmd;
			cmd.cmd_written <= sel_cmd;
			if (sel_start) begin
				cmd.start_addr <= cfg_data;
			end
			if (sel_len) begin
				cmd.len <= cfg_data;
			end
			// A write in the same cycle wins over the clear
			if (sel_cmd) begin
				cmd.cmd <= cmd_in;
			end else if (cmd.cmd_clear) begin
				cmd.cmd <= CMD_STOP;
			end
		end
	end

	// Ack only follows a write one cycle earlier
	a_ack_after_write: assert property (@(posedge frame_clk) disable iff (!frame_rst_b)
		cfg_ack |-> $past(cfg_valid));

endmodule

`default_nettype wire

/* design/read_engine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module read_engine import dma_pkg::*; (
	input  logic       frame_clk,
	input  logic       frame_rst_b,
	dma_cmd_if.eng     cmd,
	input  logic       fifo_space_ok,
	input  logic       burst_done,
	output logic       fsabo_valid,
	output fsab_mode_e fsabo_mode,
	output logic [3:0] fsabo_did,
	output logic [3:0] fsabo_subdid,
	output dma_addr_t  fsabo_addr,
	output logic [3:0] fsabo_len,
	input  logic       fsabo_credit
);

	localparam int CRED_W = $clog2(`DMA_INIT_CREDITS + 1);
	localparam logic [CRED_W-1:0] INIT_CREDITS = CRED_W'(`DMA_INIT_CREDITS);

	logic              triggered;
	logic              pending;
	logic              rearm;
	dma_addr_t         cur_addr;
	dma_addr_t         end_addr;
	dma_addr_t         next_addr;
	logic              last_burst;
	logic              issue;
	logic [CRED_W-1:0] credits;

	assign next_addr  = cur_addr + dma_addr_t'(`DMA_BURST_BYTES);
	assign last_burst = (next_addr >= end_addr);

	// One burst at a time, and only with room and a credit
	assign issue = triggered && !pending && !rearm && (credits != '0) && fifo_space_ok;

	// Finished trigger-once returns the command to stop
	assign cmd.cmd_clear = pending && burst_done && last_burst && !rearm &&
		(cmd.cmd == CMD_TRIGGER_ONCE);

	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			triggered <= 1'b0;
			pending   <= 1'b0;
			cur_addr  <= '0;
			end_addr  <= '0;
		end else if (!triggered) begin
			// Idle, take any non-stop command
			if (cmd.cmd != CMD_STOP) begin
				triggered <= 1'b1;
				cur_addr  <= cmd.start_addr;
				end_addr  <= cmd.start_addr + cmd.len;
			end
		end else if (pending) begin
			if (burst_done) begin
				pending <= 1'b0;
				if (!last_burst) begin
					cur_addr <= next_addr;
				end else if (cmd.cmd == CMD_AUTOTRIGGER) begin
					cur_addr <= cmd.start_addr;
					end_addr <= cmd.start_addr + cmd.len;
				end else begin
					triggered <= 1'b0;
				end
			end
		end else if (rearm) begin
			// New command seen mid-transfer, acted on between bursts
			if (cmd.cmd == CMD_STOP) begin
				triggered <= 1'b0;
			end else begin
				cur_addr <= cmd.start_addr;
				end_addr <= cmd.start_addr + cmd.len;
			end
		end else if (issue) begin
			pending <= 1'b1;
		end
	end

	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			rearm <= 1'b0;
		end else if (cmd.cmd_written && triggered) begin
			rearm <= 1'b1;
		end else if (!pending) begin
			rearm <= 1'b0;
		end
	end

	// Credit counter, one spent per request, one back per return pulse
	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			credits <= INIT_CREDITS;
		end else begin
			case ({fsabo_credit, fsabo_valid})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign fsabo_valid  = issue;
	assign fsabo_mode   = issue ? FSAB_READ : FSAB_IDLE;
	assign fsabo_did    = `DMA_FSAB_DID;
	assign fsabo_subdid = `DMA_FSAB_SUBDID;
	assign fsabo_addr   = cur_addr;
	assign fsabo_len    = 4'(`DMA_BURST_BEATS);

	// Bus never returns more credits than were spent
	a_credit_balance: assert property (@(posedge frame_clk) disable iff (!frame_rst_b)
		(fsabo_credit && !fsabo_valid) |-> (credits < INIT_CREDITS));

	// FIFO reports a burst end only while one is outstanding
	a_done_pending: assert property (@(posedge frame_clk) disable iff (!frame_rst_b)
		burst_done |-> pending);

endmodule

`default_nettype wire

/* design/beat_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module beat_fifo import dma_pkg::*; (
	input  logic       frame_clk,
	input  logic       frame_rst_b,
	input  logic       fsabi_valid,
	input  logic [3:0] fsabi_did,
	input  logic [3:0] fsabi_subdid,
	input  dma_word_t  fsabi_data,
	input  logic       request,
	output dma_word_t  data,
	output logic       data_ready,
	output logic       fifo_empty,
	output logic       fifo_space_ok,
	output logic       burst_done
);

	localparam int DEPTH  = `DMA_FIFO_DEPTH;
	localparam int PTR_W  = $clog2(DEPTH);
	localparam int CNT_W  = $clog2(DEPTH + 1);
	localparam int BEAT_W = $clog2(`DMA_BURST_BEATS);

	dma_word_t         mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic [BEAT_W-1:0] beat_cnt;
	logic              wr_en;
	logic              rd_en;

	// Only beats addressed to this controller
	assign wr_en = fsabi_valid && (fsabi_did == `DMA_FSAB_DID) &&
		(fsabi_subdid == `DMA_FSAB_SUBDID);
	assign rd_en = request && !fifo_empty;

	assign fifo_empty    = (count == '0);
	assign fifo_space_ok = (count <= CNT_W'(DEPTH - `DMA_BURST_BEATS));

	always_ff @(posedge frame_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= fsabi_data;
		end
		if (rd_en) begin
			data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge frame_clk or negedge frame_rst_b) begin
		if (!frame_rst_b) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			beat_cnt   <= '0;
			data_ready <= 1'b0;
			burst_done <= 1'b0;
		end else begin
			data_ready <= rd_en;
			// Eighth beat closes the burst, counter wraps to zero
			burst_done <= wr_en && (beat_cnt == BEAT_W'(`DMA_BURST_BEATS - 1));
			if (wr_en) begin
				wr_ptr   <= wr_ptr + 1'b1;
				beat_cnt <= beat_cnt + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Engine only requests a burst with room for all of it
	a_no_write_full: assert property (@(posedge frame_clk) disable iff (!frame_rst_b)
		wr_en |-> (count != CNT_W'(DEPTH)));

endmodule

`default_nettype wire

/* design/dma_read_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_read_ctrl import dma_pkg::*; (
	input  logic        frame_clk,
	input  logic        frame_rst_b,
	// Configuration write bus
	input  logic        cfg_valid,
	input  logic [3:0]  cfg_did,
	input  dma_addr_t   cfg_addr,
	input  logic [31:0] cfg_data,
	output logic        cfg_ack,
	// System bus requests
	output logic        fsabo_valid,
	output fsab_mode_e  fsabo_mode,
	output logic [3:0]  fsabo_did,
	output logic [3:0]  fsabo_subdid,
	output dma_addr_t   fsabo_addr,
	output logic [3:0]  fsabo_len,
	input  logic        fsabo_credit,
	// System bus responses
	input  logic        fsabi_valid,
	input  logic [3:0]  fsabi_did,
	input  logic [3:0]  fsabi_subdid,
	input  dma_word_t   fsabi_data,
	// User port
	input  logic        request,
	output dma_word_t   data,
	output logic        data_ready,
	output logic        fifo_empty
);

	logic fifo_space_ok;
	logic burst_done;

	dma_cmd_if cmd_bus ();

	csr_decode decode_i (
		.frame_clk   (frame_clk),
		.frame_rst_b (frame_rst_b),
		.cfg_valid   (cfg_valid),
		.cfg_did     (cfg_did),
		.cfg_addr    (cfg_addr),
		.cfg_data    (cfg_data),
		.cfg_ack     (cfg_ack),
		.cmd         (cmd_bus.cfg)
	);

	read_engine engine_i (
		.frame_clk     (frame_clk),
		.frame_rst_b   (frame_rst_b),
		.cmd           (cmd_bus.eng),
		.fifo_space_ok (fifo_space_ok),
		.burst_done    (burst_done),
		.fsabo_valid   (fsabo_valid),
		.fsabo_mode    (fsabo_mode),
		.fsabo_did     (fsabo_did),
		.fsabo_subdid  (fsabo_subdid),
		.fsabo_addr    (fsabo_addr),
		.fsabo_len     (fsabo_len),
		.fsabo_credit  (fsabo_credit)
	);

	beat_fifo fifo_i (
		.frame_clk     (frame_clk),
		.frame_rst_b   (frame_rst_b),
		.fsabi_valid   (fsabi_valid),
		.fsabi_did     (fsabi_did),
		.fsabi_subdid  (fsabi_subdid),
		.fsabi_data    (fsabi_data),
		.request       (request),
		.data          (data),
		.data_ready    (data_ready),
		.fifo_empty    (fifo_empty),
		.fifo_space_ok (fifo_space_ok),
		.burst_done    (burst_done)
	);

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic frame_clk,
	output logic frame_rst_b
);

	// 10 ns period
	initial begin
		frame_clk = 1'b0;
		forever #5 frame_clk = ~frame_clk;
	end

	// Reset held for 10 rising edges, released just after an edge
	initial begin
		frame_rst_b = 1'b0;
		repeat (10) @(posedge frame_clk);
		#1;
		frame_rst_b = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/dma_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module dma_checker import dma_pkg::*; (
	input logic       frame_clk,
	input logic       frame_rst_b,
	input logic       cfg_ack,
	input logic       fsabo_valid,
	input logic [1:0] fsabo_mode,
	input logic [3:0] fsabo_did,
	input logic [3:0] fsabo_subdid,
	input dma_addr_t  fsabo_addr,
	input logic [3:0] fsabo_len,
	input logic       fsabo_credit,
	input logic       data_ready,
	input dma_word_t  data
);

	dma_addr_t exp_start;
	dma_addr_t exp_len;
	dma_addr_t exp_addr;
	int        word_cnt;
	int        req_cnt;
	int        ack_cnt;
	int        err_cnt;
	// Requests not yet paid back by a credit pulse
	int        outstanding;

	initial begin
		exp_start   = '0;
		exp_len     = '0;
		word_cnt    = 0;
		req_cnt     = 0;
		ack_cnt     = 0;
		err_cnt     = 0;
		outstanding = 0;
	end

	// A zero length means no request or data is allowed
	task automatic begin_test(input dma_addr_t start, input dma_addr_t len);
		exp_start = start;
		exp_len   = len;
		word_cnt  = 0;
		req_cnt   = 0;
	endtask

	// Byte offset wraps at the block length, autotrigger restarts the block
	function automatic dma_addr_t predicted(input int offset);
		return exp_start + (dma_addr_t'(offset) % exp_len);
	endfunction

	always @(posedge frame_clk) begin
		if (frame_rst_b) begin
			if (cfg_ack) begin
				ack_cnt++;
			end
			if (data_ready) begin
				if (exp_len == '0) begin
					$display("At %0t: data_ready while no transfer was started", $time);
					err_cnt++;
				end else if (data !== dma_word_t'(predicted(word_cnt * 8))) begin
					$display("FAILED %0t data: got %h expected %h", $time, data,
						dma_word_t'(predicted(word_cnt * 8)));
					err_cnt++;
				end
				word_cnt++;
			end
			if (fsabo_valid) begin
				if (exp_len == '0) begin
					$display("At %0t: bus request while no transfer was started", $time);
					err_cnt++;
				end else begin
					exp_addr = predicted(req_cnt * `DMA_BURST_BYTES);
					if (fsabo_addr !== exp_addr) begin
						$display("FAILED %0t fsabo_addr: got %h expected %h", $time,
							fsabo_addr, exp_addr);
						err_cnt++;
					end
					if (fsabo_mode !== FSAB_READ || fsabo_len !== 4'd8) begin
						$display("FAILED %0t fsabo_mode/fsabo_len: got %0d/%0d expected %0d/8",
							$time, fsabo_mode, fsabo_len, FSAB_READ);
						err_cnt++;
					end
					if (fsabo_did !== `DMA_FSAB_DID || fsabo_subdid !== `DMA_FSAB_SUBDID) begin
						$display("FAILED %0t fsabo_did/fsabo_subdid: got %h/%h expected %h/%h",
							$time, fsabo_did, fsabo_subdid, `DMA_FSAB_DID, `DMA_FSAB_SUBDID);
						err_cnt++;
					end
				end
				if (outstanding >= `DMA_INIT_CREDITS) begin
					$display("At %0t: bus request issued with no credit left", $time);
					err_cnt++;
				end
				req_cnt++;
			end
			outstanding = outstanding + (fsabo_valid ? 1 : 0) - (fsabo_credit ? 1 : 0);
		end
	end

endmodule

`default_nettype wire

/* sim/dma_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module dma_tb import dma_pkg::*; ();

	logic        frame_clk;
	logic        frame_rst_b;
	logic        cfg_valid;
	logic [3:0]  cfg_did;
	dma_addr_t   cfg_addr;
	logic [31:0] cfg_data;
	logic        cfg_ack;
	logic        fsabo_valid;
	fsab_mode_e  fsabo_mode;
	logic [3:0]  fsabo_did;
	logic [3:0]  fsabo_subdid;
	dma_addr_t   fsabo_addr;
	logic [3:0]  fsabo_len;
	logic        fsabo_credit;
	logic        fsabi_valid;
	logic [3:0]  fsabi_did;
	logic [3:0]  fsabi_subdid;
	dma_word_t   fsabi_data;
	logic        request;
	dma_word_t   data;
	logic        data_ready;
	logic        fifo_empty;

	// Memory model state
	dma_addr_t   addr_q[$];
	longint      due_q[$];
	longint      cycle;
	dma_addr_t   burst_addr;
	int          beats_left;
	int          beat_idx;
	int          beats_sent;
	int          crd_dly;
	int          pop_mode;
	logic        hold;
	logic        gap_bit;
	logic        pop_bit;
	logic [31:0] lfsr_state;

	int          fail_cnt;
	int          pass_tests;
	int          fail_tests;
	int          test_idx;
	logic        aborted;

	tb_clock_gen clk_i (
		.frame_clk   (frame_clk),
		.frame_rst_b (frame_rst_b)
	);

	dma_read_ctrl dut_i (.*);

	dma_checker chk_i (
		.frame_clk    (frame_clk),
		.frame_rst_b  (frame_rst_b),
		.cfg_ack      (cfg_ack),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_credit (fsabo_credit),
		.data_ready   (data_ready),
		.data         (data)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit, both bits drawn away from the rising edge
	initial begin
		lfsr_state = 32'hc659_164d;
		gap_bit    = 1'b0;
		pop_bit    = 1'b0;
		forever begin
			@(negedge frame_clk);
			lfsr_state = lfsr_next(lfsr_state);
			gap_bit    = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
			pop_bit    = lfsr_state[0];
		end
	end

	// Bus memory: eight beats per request, each beat holds its own address
	initial begin
		fsabi_valid  = 1'b0;
		fsabi_did    = 4'h0;
		fsabi_subdid = 4'h0;
		fsabi_data   = '0;
		fsabo_credit = 1'b0;
		cycle        = 0;
		beats_left   = 0;
		beat_idx     = 0;
		beats_sent   = 0;
		forever begin
			@(posedge frame_clk);
			if (frame_rst_b && fsabo_valid) begin
				addr_q.push_back(fsabo_addr);
				// Credit delay in the record counts in bursts of eight cycles
				due_q.push_back(cycle + longint'(crd_dly * `DMA_BURST_BEATS));
			end
			#1;
			cycle++;
			fsabi_valid  = 1'b0;
			fsabo_credit = 1'b0;
			if (beats_left == 0 && addr_q.size() > 0) begin
				burst_addr = addr_q.pop_front();
				beats_left = 8;
				beat_idx   = 0;
			end
			if (beats_left > 0 && !gap_bit) begin
				fsabi_valid  = 1'b1;
				fsabi_did    = `DMA_FSAB_DID;
				fsabi_subdid = `DMA_FSAB_SUBDID;
				fsabi_data   = dma_word_t'(burst_addr + dma_addr_t'(beat_idx * 8));
				beat_idx++;
				beats_left--;
				beats_sent++;
			end
			if (due_q.size() > 0 && cycle >= due_q[0]) begin
				void'(due_q.pop_front());
				fsabo_credit = 1'b1;
			end
		end
	end

	// User pops, always or gated by the LFSR, none while held
	initial begin
		request = 1'b0;
		forever begin
			@(posedge frame_clk);
			#1;
			request = !hold && (pop_mode != 1 || pop_bit);
		end
	end

	task automatic tick();
		@(posedge frame_clk);
		#1;
	endtask

	task automatic cfg_write(input logic [3:0] did, input dma_addr_t addr,
		input logic [31:0] value, input logic exp_ack);
		int acks;
		acks      = chk_i.ack_cnt;
		cfg_valid = 1'b1;
		cfg_did   = did;
		cfg_addr  = addr;
		cfg_data  = value;
		tick();
		cfg_valid = 1'b0;
		// Ack is due one cycle after the write
		tick();
		tick();
		if ((chk_i.ack_cnt != acks) != exp_ack) begin
			$display("At %0t: write to offset %h with id %h %s", $time, addr, did,
				exp_ack ? "got no cfg_ack" : "was acknowledged but should be ignored");
			fail_cnt++;
		end
	endtask

	task automatic timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		aborted = 1'b1;
		fail_cnt++;
	endtask

	task automatic wait_words(input int n, input int limit);
		int i;
		i = 0;
		while (!aborted && chk_i.word_cnt < n) begin
			if (i == limit) begin
				timeout($sformatf("%0d data words, %0d arrived", n, chk_i.word_cnt));
			end else begin
				tick();
				i++;
			end
		end
	endtask

	task automatic wait_beats(input int n, input int limit);
		int i;
		i = 0;
		while (!aborted && beats_sent < n) begin
			if (i == limit) begin
				timeout("the FIFO to fill while pops were held");
			end else begin
				tick();
				i++;
			end
		end
	endtask

	// Idle bus, empty FIFO and all credits home for 40 cycles in a row
	task automatic wait_quiet();
		int i;
		int calm;
		i    = 0;
		calm = 0;
		while (!aborted && calm < 40) begin
			if (i == 5000) begin
				timeout("the controller to go idle");
			end else begin
				tick();
				i++;
				if (fifo_empty && !fsabo_valid && beats_left == 0 && addr_q.size() == 0 &&
					due_q.size() == 0) begin
					calm++;
				end else begin
					calm = 0;
				end
			end
		end
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED %0t %s: got %0d expected %0d", $time, name, got, exp);
			fail_cnt++;
		end
	endtask

	task automatic finish_test(input int errs);
		if (fail_cnt + chk_i.err_cnt == errs) begin
			pass_tests++;
			$display("test %0d ok: %0d words, %0d requests", test_idx, chk_i.word_cnt,
				chk_i.req_cnt);
		end else begin
			fail_tests++;
			$display("test %0d had errors: %0d words, %0d requests", test_idx,
				chk_i.word_cnt, chk_i.req_cnt);
		end
		test_idx++;
	endtask

	task automatic run_test(input int kind, input dma_addr_t start, input dma_addr_t len,
		input int cmd_v, input int pop, input int dly, input int words);
		int errs;
		int base;
		errs     = fail_cnt + chk_i.err_cnt;
		base     = beats_sent;
		crd_dly  = dly;
		pop_mode = pop;
		hold     = (pop == 2);
		chk_i.begin_test((kind == 0) ? start : '0, (kind == 0) ? len : '0);
		if (kind == 0) begin
			cfg_write(`DMA_CFG_DID, dma_addr_t'(`DMA_REG_START), start, 1'b1);
			cfg_write(`DMA_CFG_DID, dma_addr_t'(`DMA_REG_LEN), len, 1'b1);
			cfg_write(`DMA_CFG_DID, dma_addr_t'(`DMA_REG_CMD), cmd_v, 1'b1);
			if (hold) begin
				// FIFO should take exactly its depth, then requests stop
				wait_beats(base + `DMA_FIFO_DEPTH, 3000);
				repeat (100) tick();
				check_value("beats_accepted", beats_sent - base, `DMA_FIFO_DEPTH);
				check_value("word_cnt", chk_i.word_cnt, 0);
				hold = 1'b0;
			end
			wait_words(words, 20000);
			if (cmd_v == 2) begin
				cfg_write(`DMA_CFG_DID, dma_addr_t'(`DMA_REG_CMD), 32'd0, 1'b1);
			end
			wait_quiet();
			// Autotrigger stops at a burst boundary, so count what the bus delivered
			check_value("word_cnt", chk_i.word_cnt,
				(cmd_v == 2) ? beats_sent - base : words);
			check_value("req_cnt", chk_i.req_cnt,
				(cmd_v == 2) ? (beats_sent - base) / 8 : words / 8);
		end else begin
			// Wrong device id, then an unused offset, neither may start anything
			cfg_write(`DMA_CFG_DID ^ 4'hf, dma_addr_t'(`DMA_REG_CMD), 32'd1, 1'b0);
			cfg_write(`DMA_CFG_DID, dma_addr_t'(32'hc), 32'd1, 1'b0);
			repeat (60) tick();
			cfg_write(`DMA_CFG_DID, dma_addr_t'(`DMA_REG_START), start, 1'b1);
			cfg_write(`DMA_CFG_DID, dma_addr_t'(`DMA_REG_LEN), len, 1'b1);
		end
		finish_test(errs);
	endtask

	initial begin
		int        fd;
		int        n;
		int        i;
		int        errs;
		int        kind;
		int        cmd_v;
		int        pop_v;
		int        dly_v;
		int        words_v;
		dma_addr_t start_v;
		dma_addr_t len_v;
		string     line;
		cfg_valid  = 1'b0;
		cfg_did    = 4'h0;
		cfg_addr   = '0;
		cfg_data   = '0;
		hold       = 1'b0;
		pop_mode   = 0;
		crd_dly    = 0;
		fail_cnt   = 0;
		pass_tests = 0;
		fail_tests = 0;
		test_idx   = 0;
		aborted    = 1'b0;

		// Reset state, and no request while the command is stop
		errs = 0;
		chk_i.begin_test('0, '0);
		i = 0;
		while (!frame_rst_b && i < 100) begin
			tick();
			i++;
		end
		if (!frame_rst_b) begin
			timeout("reset to be released");
		end
		check_value("fsabo_valid", fsabo_valid, 0);
		check_value("data_ready", data_ready, 0);
		check_value("fifo_empty", fifo_empty, 1);
		check_value("cfg_ack", cfg_ack, 0);
		repeat (20) tick();
		finish_test(errs);

		fd = $fopen("sim/dma_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file sim/dma_stim.txt");
			fail_cnt++;
		end else begin
			while (!aborted && !$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) begin
					n = $sscanf(line, "%d %h %h %d %d %d %d", kind, start_v, len_v, cmd_v,
						pop_v, dly_v, words_v);
					if (n == 7) begin
						run_test(kind, start_v, len_v, cmd_v, pop_v, dly_v, words_v);
					end
				end
			end
			$fclose(fd);
		end

		$display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
		if (fail_tests == 0 && fail_cnt == 0 && chk_i.err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/dma_stim.txt */
# kind start len cmd pop dly words (start and len in hex)
# kind 0 transfer, 1 decode probe; cmd 1 once, 2 auto; pop 0 always, 1 lfsr, 2 held
0 00001000 00000100 1 0 0 32
0 00002000 00000100 1 1 3 32
0 00003000 000000c0 2 0 0 48
0 00008000 00000400 1 2 0 128
0 00010000 00000200 1 0 40 64
1 00004000 00000080 1 0 0 0
0 00020040 00000100 2 1 5 80

/* sim.f */
+incdir+design
design/dma_pkg.sv
design/dma_cmd_if.sv
design/csr_decode.sv
design/read_engine.sv
design/beat_fifo.sv
design/dma_read_ctrl.sv
sim/tb_clock_gen.sv
sim/dma_checker.sv
sim/dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(OBJ_DIR)/V%: $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

check: run

clean:
	rm -rf $(OBJ_DIR) $(LOG)
